// ==== dv/fetch_unit_props.sv ====
`timescale 1ns/1ps

module fetch_unit_props (
    input logic             clk,
    input logic             reset,
    input logic             inst_req,
    input fetch_pkg::addr_t inst_addr,
    input logic             br_stall,
    input logic             cancel,
    input logic             out_valid,
    input logic             dec_allow_in,
    input fetch_pkg::addr_t out_pc,
    input fetch_pkg::inst_t out_inst,
    input logic             out_adef
);

    // no memory request for a misaligned address
    a_req_aligned: assert property (@(posedge clk) disable iff (reset)
        inst_req |-> (inst_addr[1:0] == 2'b00))
        else $error("request with misaligned address %h", inst_addr);

    // branch stall blocks requests
    a_stall_no_req: assert property (@(posedge clk) disable iff (reset)
        br_stall |-> !inst_req)
        else $error("request issued under br_stall");

    // refused item holds until decode takes it, unless a redirect kills it
    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        (!$past(reset) && $past(out_valid && !dec_allow_in) && !cancel) |->
        (out_valid && $stable(out_pc) && $stable(out_inst) && $stable(out_adef)))
        else $error("decode outputs changed while stalled");

endmodule

// ==== dv/fetch_unit_tb.sv ====
`timescale 1ns/1ps

module fetch_unit_tb;

    import fetch_pkg::*;

    localparam int    NUM_DELIV = 400;
    localparam int    WD_CYCLES = NUM_DELIV * 12 + 100;
    localparam addr_t KEY       = 32'h5a3c_96e1;

    logic  clk;
    logic  reset;
    logic  inst_req, inst_addr_ok, inst_data_ok;
    addr_t inst_addr;
    inst_t inst_rdata;
    logic  br_taken, br_stall, ex_valid, ertn_valid, refetch_flush;
    addr_t br_target, ex_entry, era_pc, refetch_pc;
    logic  dec_allow_in, out_valid, out_adef;
    addr_t out_pc;
    inst_t out_inst;

    // accepted addresses and their due cycles for the memory model
    addr_t addr_q[$];
    int    due_q[$];
    int    cyc;
    int    last_due;

    // reference state
    int    deliveries;
    addr_t exp_pc;
    int    pend_prio;
    addr_t pend_tgt;

    // stimulus state
    int    seen;
    bit    redir_wait;
    bit    script_done;

    fetch_unit fetch_unit_inst (.*);

    bind fetch_unit fetch_unit_props fetch_unit_props_inst (
        .clk(clk), .reset(reset), .inst_req(inst_req), .inst_addr(inst_addr),
        .br_stall(br_stall), .cancel(cancel), .out_valid(out_valid),
        .dec_allow_in(dec_allow_in), .out_pc(out_pc), .out_inst(out_inst),
        .out_adef(out_adef)
    );

    always #2 clk = ~clk;

    // expected pc of the next delivery
    function automatic addr_t next_pc(addr_t prev, bit redir, addr_t tgt);
        if (redir) begin
            return tgt;
        end
        return prev + 32'd4;
    endfunction

    task automatic fail_now();
        $display("Verification failed");
        $fatal(1, "mismatch on decode output");
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_inst(string name, inst_t got, inst_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
            fail_now();
        end
    endtask

    // memory responder answers in order after 1 to 4 cycles
    always @(posedge clk) begin
        int lat;
        int due;
        cyc++;
        if (inst_data_ok) begin
            void'(addr_q.pop_front());
            void'(due_q.pop_front());
        end
        if (inst_req && inst_addr_ok) begin
            lat = int'($urandom % 4) + 1;
            due = cyc - 1 + lat;
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            addr_q.push_back(inst_addr);
            due_q.push_back(due);
        end
        inst_addr_ok <= ($urandom % 100) < 70;
        if (addr_q.size() > 0 && due_q[0] <= cyc) begin
            inst_data_ok <= 1'b1;
            inst_rdata   <= addr_q[0] ^ KEY;
        end else begin
            inst_data_ok <= 1'b0;
        end
    end

    // redirects, stall and decode back-pressure
    always @(posedge clk) begin
        int pick;
        if (!reset) begin
            // at most one redirect group between two deliveries
            if (out_valid && dec_allow_in) begin
                seen++;
                redir_wait = 1'b0;
            end
            br_taken      <= 1'b0;
            ex_valid      <= 1'b0;
            ertn_valid    <= 1'b0;
            refetch_flush <= 1'b0;
            dec_allow_in  <= ($urandom % 100) < 75;
            br_stall      <= ($urandom % 100) < 10;
            if (!redir_wait && seen >= 16) begin
                if (seen >= 40 && !script_done) begin
                    // misaligned branch target
                    br_taken    <= 1'b1;
                    br_target   <= 32'h1c00_0102;
                    script_done = 1'b1;
                    redir_wait  = 1'b1;
                end else if (($urandom % 100) < 6) begin
                    pick = int'($urandom % 15) + 1;
                    refetch_flush <= pick[0];
                    ex_valid      <= pick[1];
                    ertn_valid    <= pick[2];
                    br_taken      <= pick[3];
                    refetch_pc    <= 32'h1c00_0000 | ($urandom & 32'h0000_fffc);
                    ex_entry      <= 32'h1c01_0000 | ($urandom & 32'h0000_fffc);
                    era_pc        <= 32'h1c02_0000 | ($urandom & 32'h0000_fffc);
                    // occasional misaligned branch
                    br_target     <= 32'h1c03_0000 | ($urandom & 32'h0000_fffe);
                    redir_wait = 1'b1;
                end
            end
        end
    end

    // reference tracking and comparison
    always @(posedge clk) begin
        addr_t exp;
        if (!reset) begin
            // keep the highest-priority redirect seen
            // priority 0 is refetch and beats everything
            if (refetch_flush) begin
                pend_prio = 0;
                pend_tgt  = refetch_pc;
            end else if (ex_valid && pend_prio >= 1) begin
                pend_prio = 1;
                pend_tgt  = ex_entry;
            end else if (ertn_valid && pend_prio >= 2) begin
                pend_prio = 2;
                pend_tgt  = era_pc;
            end else if (br_taken && pend_prio >= 3) begin
                pend_prio = 3;
                pend_tgt  = br_target;
            end
            if (out_valid && dec_allow_in) begin
                exp = next_pc(exp_pc, pend_prio < 4, pend_tgt);
                check_addr("out_pc", out_pc, exp);
                check_flag("out_adef", out_adef, exp[1:0] != 2'b00);
                if (exp[1:0] == 2'b00) begin
                    check_inst("out_inst", out_inst, exp ^ KEY);
                end
                exp_pc    = exp;
                pend_prio = 4;
                deliveries++;
            end
        end
    end

    // watchdog
    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles with %0d deliveries", WD_CYCLES, deliveries);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(18146));
        clk = 1'b0;
        reset = 1'b1;
        inst_addr_ok = 1'b0;
        inst_data_ok = 1'b0;
        inst_rdata = '0;
        br_taken = 1'b0;
        br_target = '0;
        br_stall = 1'b0;
        ex_valid = 1'b0;
        ex_entry = '0;
        ertn_valid = 1'b0;
        era_pc = '0;
        refetch_flush = 1'b0;
        refetch_pc = '0;
        dec_allow_in = 1'b0;
        cyc = 0;
        last_due = 0;
        deliveries = 0;
        // one step before the first delivery at 0x1c000000
        exp_pc = 32'h1c00_0000 - 32'd4;
        pend_prio = 4;
        pend_tgt = '0;
        seen = 0;
        redir_wait = 1'b0;
        script_done = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        wait (deliveries == NUM_DELIV);
        @(posedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== fetch_unit.f ====
+incdir+src
src/fetch_pkg.sv
src/redirect_hold.sv
src/pc_gen.sv
src/fetch_tracker.sv
src/fetch_unit.sv
dv/fetch_unit_props.sv
dv/fetch_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch unit testbench with Verilator
# exit status is nonzero unless the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f fetch_unit.f \
    --top-module fetch_unit_tb \
    --Mdir obj_dir \
    -o fetch_unit_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/fetch_unit_sim | tee /dev/stderr | grep -qx "Verification passed" \
    && echo "run ok" \
    || { echo "run not ok"; exit 1; }

// ==== src/fetch_consts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// fetch address width
`define FETCH_ADDR_W 32

// instruction word width
`define FETCH_INST_W 32

// one step before the first fetch at 0x1c000000
`define FETCH_RESET_PC 32'h1bff_fffc

// sequential pc increment
`define FETCH_STEP 32'h0000_0004

// outstanding request counter width
`define FETCH_CNT_W 8

`endif

// ==== src/fetch_pkg.sv ====
`include "fetch_consts.svh"

package fetch_pkg;

    // fetch address, byte granular
    typedef logic [`FETCH_ADDR_W-1:0] addr_t;

    // raw instruction word from memory
    typedef logic [`FETCH_INST_W-1:0] inst_t;

    // accepted requests whose data has not come back yet
    typedef logic [`FETCH_CNT_W-1:0] pend_cnt_t;

endpackage

// ==== src/fetch_tracker.sv ====
`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_tracker (
    input  logic             clk,
    input  logic             reset,
    input  logic             handoff,
    input  logic             cancel,
    input  fetch_pkg::addr_t pc,
    input  logic             next_adef,
    input  logic             inst_req,
    input  logic             inst_addr_ok,
    input  logic             inst_data_ok,
    input  fetch_pkg::inst_t inst_rdata,
    input  logic             dec_allow_in,
    output logic             allow_in,
    output logic             out_valid,
    output fetch_pkg::addr_t out_pc,
    output fetch_pkg::inst_t out_inst,
    output logic             out_adef
);

    import fetch_pkg::*;

    // requests accepted, data not yet back
    pend_cnt_t pend_cnt;
    logic      accept;

    // fetch-stage state
    logic      fs_valid;
    logic      fs_adef;
    logic      cancel_r;
    logic      cancel_tak;
    logic      live;

    // one-word holding buffer for a stalled decoder
    logic      buf_valid;
    inst_t     buf_inst;

    // where this stage's word comes from
    logic      from_mem;
    logic      from_buf;
    logic      ready_go;
    logic      xfer;

    assign accept = inst_req && inst_addr_ok;

    // outstanding count
    // accept and return in the same cycle cancel out
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_cnt <= '0;
        end else if (accept && !inst_data_ok) begin
            pend_cnt <= pend_cnt + pend_cnt_t'(1);
        end else if (!accept && inst_data_ok) begin
            pend_cnt <= pend_cnt - pend_cnt_t'(1);
        end
    end

    // cancel latch
    // a redirect marks the current item dead until a new address arrives
    always_ff @(posedge clk) begin
        if (reset) begin
            cancel_r <= 1'b0;
        end else if (handoff) begin
            cancel_r <= 1'b0;
        end else if (cancel) begin
            cancel_r <= 1'b1;
        end
    end

    assign cancel_tak = cancel || cancel_r;

    // item in the stage that may still reach decode
    assign live = fs_valid && !cancel_tak;

    // data matching is by count, returns are in order
    // count one, ours is the next word to come back
    // count zero, ours already came back and sits in the buffer
    // anything above one is stale traffic from cancelled fetches
    assign from_mem = fs_valid && !fs_adef && (pend_cnt == pend_cnt_t'(1));
    assign from_buf = fs_valid && !fs_adef && (pend_cnt == '0) && buf_valid;

    // misaligned item is done as soon as it is here
    assign ready_go = fs_adef || (from_mem && inst_data_ok) || from_buf;

    assign out_valid = live && ready_go;
    assign xfer      = out_valid && dec_allow_in;

    // room for a new address, stage empty or dead, or leaving now
    assign allow_in = !live || (dec_allow_in && ready_go);

    // stage valid
    // a handoff under a live redirect loads a dead item
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (handoff) begin
            fs_valid <= !cancel;
        end else if (xfer) begin
            fs_valid <= 1'b0;
        end
    end

    // misaligned flag travels with the address
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_adef <= 1'b0;
        end else if (handoff) begin
            fs_adef <= next_adef;
        end
    end

    // buffer valid
    // fill when our word shows up and decode is not taking it
    // a new item always starts with an empty buffer
    always_ff @(posedge clk) begin
        if (reset) begin
            buf_valid <= 1'b0;
        end else if (handoff || xfer) begin
            buf_valid <= 1'b0;
        end else if (live && from_mem && inst_data_ok && !dec_allow_in) begin
            buf_valid <= 1'b1;
        end
    end

    // buffer word
    always_ff @(posedge clk) begin
        if (from_mem && inst_data_ok && !dec_allow_in) begin
            buf_inst <= inst_rdata;
        end
    end

    // decode side
    // a misaligned fetch carries no word
    assign out_pc   = pc;
    assign out_adef = fs_adef;
    assign out_inst = fs_adef  ? '0 :
                      from_buf ? buf_inst : inst_rdata;

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic             clk,
    input  logic             reset,

    // instruction memory
    output logic             inst_req,
    output fetch_pkg::addr_t inst_addr,
    input  logic             inst_addr_ok,
    input  logic             inst_data_ok,
    input  fetch_pkg::inst_t inst_rdata,

    // redirects from later stages
    input  logic             br_taken,
    input  fetch_pkg::addr_t br_target,
    input  logic             br_stall,
    input  logic             ex_valid,
    input  fetch_pkg::addr_t ex_entry,
    input  logic             ertn_valid,
    input  fetch_pkg::addr_t era_pc,
    input  logic             refetch_flush,
    input  fetch_pkg::addr_t refetch_pc,

    // decode
    input  logic             dec_allow_in,
    output logic             out_valid,
    output fetch_pkg::addr_t out_pc,
    output fetch_pkg::inst_t out_inst,
    output logic             out_adef
);

    import fetch_pkg::*;

    // fetch-stage pc and its successor
    addr_t pc;
    addr_t pc_next;

    // stage coupling
    logic  cancel;
    logic  handoff;
    logic  next_adef;
    logic  allow_in;

    // next pc choice and redirect holding
    redirect_hold redirect_hold_inst (
        .clk           (clk),
        .reset         (reset),
        .handoff       (handoff),
        .pc            (pc),
        .br_taken      (br_taken),
        .br_target     (br_target),
        .ex_valid      (ex_valid),
        .ex_entry      (ex_entry),
        .ertn_valid    (ertn_valid),
        .era_pc        (era_pc),
        .refetch_flush (refetch_flush),
        .refetch_pc    (refetch_pc),
        .pc_next       (pc_next),
        .cancel        (cancel)
    );

    // pre-fetch, request side
    pc_gen pc_gen_inst (
        .clk          (clk),
        .reset        (reset),
        .pc_next      (pc_next),
        .allow_in     (allow_in),
        .br_stall     (br_stall),
        .inst_addr_ok (inst_addr_ok),
        .pc           (pc),
        .next_adef    (next_adef),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .handoff      (handoff)
    );

    // fetch, response side
    fetch_tracker fetch_tracker_inst (
        .clk          (clk),
        .reset        (reset),
        .handoff      (handoff),
        .cancel       (cancel),
        .pc           (pc),
        .next_adef    (next_adef),
        .inst_req     (inst_req),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .dec_allow_in (dec_allow_in),
        .allow_in     (allow_in),
        .out_valid    (out_valid),
        .out_pc       (out_pc),
        .out_inst     (out_inst),
        .out_adef     (out_adef)
    );

endmodule

// ==== src/pc_gen.sv ====
`timescale 1ns/1ps

`include "fetch_consts.svh"

module pc_gen (
    input  logic             clk,
    input  logic             reset,
    input  fetch_pkg::addr_t pc_next,
    input  logic             allow_in,
    input  logic             br_stall,
    input  logic             inst_addr_ok,
    output fetch_pkg::addr_t pc,
    output logic             next_adef,
    output logic             inst_req,
    output fetch_pkg::addr_t inst_addr,
    output logic             handoff
);

    // pre-fetch may pass its address on
    logic ready;

    // misaligned fetch address, low two bits must be zero
    assign next_adef = (pc_next[1:0] != 2'b00);

    // memory request
    // only when the fetch stage has room for the address
    // never for a misaligned address, never while a branch stalls us
    assign inst_req = !reset && !br_stall && allow_in && !next_adef;

    // address goes straight out, no translation
    assign inst_addr = pc_next;

    // ready on an accepted request
    // a misaligned address needs no memory, it moves on with its flag
    assign ready = (inst_req && inst_addr_ok) || next_adef;

    // address moves into the fetch stage
    assign handoff = ready && allow_in;

    // fetch-stage pc
    // this is the pc of the word the fetch stage waits for
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `FETCH_RESET_PC;
        end else if (handoff) begin
            pc <= pc_next;
        end
    end

endmodule

// ==== src/redirect_hold.sv ====
`timescale 1ns/1ps

`include "fetch_consts.svh"

module redirect_hold (
    input  logic             clk,
    input  logic             reset,
    input  logic             handoff,
    input  fetch_pkg::addr_t pc,
    input  logic             br_taken,
    input  fetch_pkg::addr_t br_target,
    input  logic             ex_valid,
    input  fetch_pkg::addr_t ex_entry,
    input  logic             ertn_valid,
    input  fetch_pkg::addr_t era_pc,
    input  logic             refetch_flush,
    input  fetch_pkg::addr_t refetch_pc,
    output fetch_pkg::addr_t pc_next,
    output logic             cancel
);

    import fetch_pkg::*;

    // source index is also priority, 0 wins
    // 0 refetch, 1 exception, 2 exception return, 3 branch
    localparam int unsigned NUM_SRC = 4;

    logic [NUM_SRC-1:0] pulse;
    addr_t              src_pc [NUM_SRC];

    // held redirects, waiting for the next clean handoff
    logic [NUM_SRC-1:0] held;
    addr_t              held_pc [NUM_SRC];

    // live one-cycle pulses, packed by priority
    assign pulse = {br_taken, ertn_valid, ex_valid, refetch_flush};

    assign src_pc[0] = refetch_pc;
    assign src_pc[1] = ex_entry;
    assign src_pc[2] = era_pc;
    assign src_pc[3] = br_target;

    // any redirect this cycle kills whatever is in flight
    assign cancel = |pulse;

    // taken flags
    // cleared once a handoff goes through with no new redirect
    // a handoff under cancel keeps them, the next one refetches the target
    always_ff @(posedge clk) begin
        if (reset || (handoff && !cancel)) begin
            held <= '0;
        end else begin
            for (int i = 0; i < NUM_SRC; i++) begin
                if (pulse[i]) begin
                    held[i] <= 1'b1;
                end
            end
        end
    end

    // targets, only meaningful while the flag is set
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_SRC; i++) begin
            if (pulse[i]) begin
                held_pc[i] <= src_pc[i];
            end
        end
    end

    // next pc select
    // walk from lowest priority up so the highest one is written last
    // a live pulse beats its own older latched target
    always_comb begin
        pc_next = pc + `FETCH_STEP;
        for (int i = NUM_SRC - 1; i >= 0; i--) begin
            if (pulse[i]) begin
                pc_next = src_pc[i];
            end else if (held[i]) begin
                pc_next = held_pc[i];
            end
        end
    end

endmodule
